//--- common/kb_defs.svh
// keyboard constants; codes are PS/2 set 2, row addresses follow the PC-8001 key matrix
`ifndef KB_DEFS_SVH
`define KB_DEFS_SVH

// ****************************************
// scan code values
// ****************************************

`define KB_BREAK_CODE      8'hF0   // prefix before a released key

// modifier keys, latched until their break
`define KB_CODE_SHIFT      8'h12   // left shift
`define KB_CODE_KANA       8'h13
`define KB_CODE_CTRL       8'h14   // left ctrl
`define KB_CODE_GRAPH      8'h11   // left alt stands in for graph

// ****************************************
// key matrix
// ****************************************

`define KB_ROWS            9       // table rows 1..9

// this row also reports the modifier keys
`define KB_MOD_ROW         4'h8

// modifier bits as seen at the modifier row
`define KB_MOD_BIT_SHIFT   8'h40
`define KB_MOD_BIT_KANA    8'h20
`define KB_MOD_BIT_GRAPH   8'h10
`define KB_MOD_BIT_CTRL    8'h80

// ****************************************
// key release
// ****************************************

// port 00h reads before the held key drops
// roughly one full scan of the matrix by the CPU
`define KB_RELEASE_READS   14

`endif

//--- common/kb_pkg.sv
// shared types and keymap; table entries with code 00 are empty and never match
package kb_pkg;

`include "kb_defs.svh"

   typedef logic [7:0] scan_code_t;
   typedef logic [3:0] row_addr_t;   // matrix row as read by the CPU

   // one-cycle pulse with an ordinary make code
   typedef struct packed {
      logic       valid;
      scan_code_t code;
   } key_event_t;

   typedef struct packed {
      logic shift;
      logic kana;
      logic ctrl;
      logic graph;
   } mod_state_t;

   typedef struct packed {
      logic       hit;
      logic       shift;   // key forces shift
      logic [7:0] bits;    // one-hot key bit
   } row_hit_t;

   typedef struct packed {
      logic       valid;
      row_addr_t  row;
      logic       shift;
      logic [7:0] bits;
   } held_key_t;

   typedef struct packed {
      scan_code_t code;
      logic [2:0] pos;     // bit within the row
      logic       shift;
   } keymap_entry_t;

   // ****************************************
   // keymap, rows 1..9
   // ****************************************
   localparam keymap_entry_t keymap_table [1:`KB_ROWS][0:7] = '{
      '{'{8'h5A, 3'd7, 1'b0}, '{8'h00, 3'd0, 1'b0}, '{8'h00, 3'd0, 1'b0}, '{8'h00, 3'd0, 1'b0},
        '{8'h00, 3'd0, 1'b0}, '{8'h00, 3'd0, 1'b0}, '{8'h00, 3'd0, 1'b0}, '{8'h00, 3'd0, 1'b0}},
      '{'{8'h54, 3'd0, 1'b0}, '{8'h1C, 3'd1, 1'b0}, '{8'h32, 3'd2, 1'b0}, '{8'h21, 3'd3, 1'b0},
        '{8'h23, 3'd4, 1'b0}, '{8'h24, 3'd5, 1'b0}, '{8'h2B, 3'd6, 1'b0}, '{8'h34, 3'd7, 1'b0}},
      '{'{8'h33, 3'd0, 1'b0}, '{8'h43, 3'd1, 1'b0}, '{8'h3B, 3'd2, 1'b0}, '{8'h42, 3'd3, 1'b0},
        '{8'h4B, 3'd4, 1'b0}, '{8'h3A, 3'd5, 1'b0}, '{8'h31, 3'd6, 1'b0}, '{8'h44, 3'd7, 1'b0}},
      '{'{8'h4D, 3'd0, 1'b0}, '{8'h15, 3'd1, 1'b0}, '{8'h2D, 3'd2, 1'b0}, '{8'h1B, 3'd3, 1'b0},
        '{8'h2C, 3'd4, 1'b0}, '{8'h3C, 3'd5, 1'b0}, '{8'h2A, 3'd6, 1'b0}, '{8'h1D, 3'd7, 1'b0}},
      // X Y Z [ yen ] ^ -
      '{'{8'h22, 3'd0, 1'b0}, '{8'h35, 3'd1, 1'b0}, '{8'h1A, 3'd2, 1'b0}, '{8'h5B, 3'd3, 1'b0},
        '{8'h6A, 3'd4, 1'b0}, '{8'h5D, 3'd5, 1'b0}, '{8'h55, 3'd6, 1'b0}, '{8'h4E, 3'd7, 1'b0}},
      '{'{8'h45, 3'd0, 1'b0}, '{8'h16, 3'd1, 1'b0}, '{8'h1E, 3'd2, 1'b0}, '{8'h26, 3'd3, 1'b0},
        '{8'h25, 3'd4, 1'b0}, '{8'h2E, 3'd5, 1'b0}, '{8'h36, 3'd6, 1'b0}, '{8'h3D, 3'd7, 1'b0}},
      '{'{8'h3E, 3'd0, 1'b0}, '{8'h46, 3'd1, 1'b0}, '{8'h52, 3'd2, 1'b0}, '{8'h4C, 3'd3, 1'b0},
        '{8'h41, 3'd4, 1'b0}, '{8'h49, 3'd5, 1'b0}, '{8'h4A, 3'd6, 1'b0}, '{8'h51, 3'd7, 1'b0}},
      // home, up/down, right/left, del/ins; the second of each pair is shifted
      '{'{8'h6C, 3'd0, 1'b0}, '{8'h75, 3'd1, 1'b0}, '{8'h72, 3'd1, 1'b1}, '{8'h74, 3'd2, 1'b0},
        '{8'h6B, 3'd2, 1'b1}, '{8'h71, 3'd3, 1'b0}, '{8'h70, 3'd3, 1'b1}, '{8'h00, 3'd0, 1'b0}},
      // stop (pause), f1..f5, space, esc
      '{'{8'h77, 3'd0, 1'b0}, '{8'h05, 3'd1, 1'b0}, '{8'h06, 3'd2, 1'b0}, '{8'h04, 3'd3, 1'b0},
        '{8'h0C, 3'd4, 1'b0}, '{8'h03, 3'd5, 1'b0}, '{8'h29, 3'd6, 1'b0}, '{8'h76, 3'd7, 1'b0}}
   };

endpackage

//--- keymap/key_row_decoder.sv
// one keymap row; purely combinational, a code matching no entry gives an all-zero hit
`timescale 1ns/1ps

module key_row_decoder import kb_pkg::*; #(
   parameter int ROW = 1   // table row, 1..KB_ROWS
) (
   input  scan_code_t code,
   output row_hit_t   row_hit
);

   // ****************************************
   // compare against the eight entries
   // ****************************************
   always_comb begin
      keymap_entry_t ent;
      row_hit = '0;
      for (int i = 0; i < 8; i++) begin
         ent = keymap_table[ROW][i];
         // code 00 marks an empty slot
         if ((ent.code != 8'h00) && (ent.code == code)) begin
            row_hit.hit            = 1'b1;
            row_hit.bits[ent.pos]  = 1'b1;
            row_hit.shift          = ent.shift;   // down, left, ins
         end
      end
   end

endmodule

//--- keymap/held_key_latch.sv
// held key and scan-read release; cpu_port00h is sampled unsynchronized with the iorq edge
`timescale 1ns/1ps
`include "kb_defs.svh"

module held_key_latch import kb_pkg::*; (
   input  logic       I_CLK,
   input  logic       I_RST,
   input  key_event_t key_event,
   input  row_hit_t   row_hits [1:`KB_ROWS],
   input  logic       cpu_iorq,
   input  logic       cpu_port00h,
   output held_key_t  held
);

   localparam int               CNT_W    = $clog2(`KB_RELEASE_READS);
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`KB_RELEASE_READS - 1);

   held_key_t        win;         // merged row hits
   logic [2:0]       iorq_sr;     // two sync flops plus edge history
   logic             iorq_rise;
   logic             scan_read;
   logic [CNT_W-1:0] read_cnt;

   // ****************************************
   // row merge, lowest row wins
   // ****************************************
   always_comb begin
      win = '0;
      for (int r = `KB_ROWS; r >= 1; r--) begin
         if (row_hits[r].hit) begin
            win.valid = 1'b1;
            win.row   = row_addr_t'(r);
            win.shift = row_hits[r].shift;
            win.bits  = row_hits[r].bits;
         end
      end
   end

   // ****************************************
   // CPU iorq edge
   // ****************************************
   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST) begin
         iorq_sr <= '0;
      end else begin
         iorq_sr <= {iorq_sr[1:0], cpu_iorq};
      end
   end

   assign iorq_rise = iorq_sr[1] & ~iorq_sr[2];
   assign scan_read = iorq_rise & cpu_port00h & held.valid;

   // ****************************************
   // held key and release counter
   // ****************************************
   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST) begin
         held     <= '0;
         read_cnt <= '0;
      end else if (key_event.valid) begin
         held <= win;   // unknown code drops the key, counter keeps going
      end else if (scan_read) begin
         if (read_cnt == CNT_LAST) begin
            held     <= '0;
            read_cnt <= '0;
         end else begin
            read_cnt <= read_cnt + 1'b1;
         end
      end
   end

endmodule

//--- source/scan_code_intake.sv
// byte intake; sender holds scan_code while scan_valid waits, at most one byte per two cycles
`timescale 1ns/1ps
`include "kb_defs.svh"

module scan_code_intake import kb_pkg::*; (
   input  logic       I_CLK,
   input  logic       I_RST,
   input  scan_code_t scan_code,
   input  logic       scan_valid,
   output logic       scan_ready,
   output key_event_t key_event,
   output mod_state_t mods
);

   scan_code_t byte_q;     // accepted byte
   logic       byte_vld;
   logic       accept;
   logic       brk;        // break prefix seen
   logic       ev_valid;
   scan_code_t ev_code;

   assign accept = scan_valid & scan_ready;

   // ****************************************
   // handshake
   // ****************************************
   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST) begin
         scan_ready <= 1'b1;
         byte_vld   <= 1'b0;
      end else begin
         scan_ready <= ~accept;   // one idle cycle after each byte
         byte_vld   <= accept;
      end
   end

   always_ff @(posedge I_CLK) begin
      if (accept) begin
         byte_q <= scan_code;
      end
   end

   // ****************************************
   // classify the accepted byte
   // ****************************************
   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST) begin
         brk      <= 1'b0;
         mods     <= '0;
         ev_valid <= 1'b0;
      end else begin
         ev_valid <= 1'b0;
         if (byte_vld) begin
            if (byte_q == `KB_BREAK_CODE) begin
               brk <= 1'b1;
            end else if (brk) begin
               // released key, only modifiers care
               brk <= 1'b0;
               case (byte_q)
                  `KB_CODE_SHIFT: mods.shift <= 1'b0;
                  `KB_CODE_KANA:  mods.kana  <= 1'b0;
                  `KB_CODE_CTRL:  mods.ctrl  <= 1'b0;
                  `KB_CODE_GRAPH: mods.graph <= 1'b0;
                  default:        ;
               endcase
            end else begin
               case (byte_q)
                  `KB_CODE_SHIFT: mods.shift <= 1'b1;
                  `KB_CODE_KANA:  mods.kana  <= 1'b1;
                  `KB_CODE_CTRL:  mods.ctrl  <= 1'b1;
                  `KB_CODE_GRAPH: mods.graph <= 1'b1;
                  default:        ev_valid   <= 1'b1;   // ordinary make code
               endcase
            end
         end
      end
   end

   always_ff @(posedge I_CLK) begin
      if (byte_vld) begin
         ev_code <= byte_q;
      end
   end

   assign key_event = '{valid: ev_valid, code: ev_code};

endmodule

//--- source/port_read_mux.sv
// CPU row read; key_data shows the previous cycle's address and state, modifiers win at row 8
`timescale 1ns/1ps
`include "kb_defs.svh"

module port_read_mux import kb_pkg::*; (
   input  logic       I_CLK,
   input  logic       I_RST,
   input  row_addr_t  cpu_addr,
   input  mod_state_t mods,
   input  held_key_t  held,
   output logic [7:0] key_data
);

   logic       mod_row;
   logic [7:0] data_next;

   assign mod_row = (cpu_addr == `KB_MOD_ROW);

   // ****************************************
   // priority select
   // ****************************************
   always_comb begin
      if (mod_row && mods.shift) begin
         data_next = `KB_MOD_BIT_SHIFT;
      end else if (mod_row && held.valid && held.shift) begin
         data_next = `KB_MOD_BIT_SHIFT | held.bits;   // shifted row 8 key
      end else if (mod_row && mods.kana) begin
         data_next = `KB_MOD_BIT_KANA;
      end else if (mod_row && mods.graph) begin
         data_next = `KB_MOD_BIT_GRAPH;
      end else if (mod_row && mods.ctrl) begin
         data_next = `KB_MOD_BIT_CTRL;
      end else if (held.valid && (cpu_addr == held.row)) begin
         data_next = held.bits;
      end else begin
         data_next = 8'h00;
      end
   end

   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST) begin
         key_data <= 8'h00;
      end else begin
         key_data <= data_next;   // output retiming
      end
   end

endmodule

//--- source/pc8001_keyboard.sv
// keyboard top; held key follows a make code two edges after acceptance, key_data lags a cycle
`timescale 1ns/1ps
`include "kb_defs.svh"

module pc8001_keyboard import kb_pkg::*; (
   input  logic       I_CLK,
   input  logic       I_RST,
   input  scan_code_t scan_code,
   input  logic       scan_valid,
   output logic       scan_ready,
   input  row_addr_t  cpu_addr,
   input  logic       cpu_iorq,
   input  logic       cpu_port00h,
   output logic [7:0] key_data
);

   key_event_t key_event;
   mod_state_t mods;
   row_hit_t   row_hits [1:`KB_ROWS];
   held_key_t  held;

   scan_code_intake scan_code_intake_inst (
      .I_CLK      (I_CLK),
      .I_RST      (I_RST),
      .scan_code  (scan_code),
      .scan_valid (scan_valid),
      .scan_ready (scan_ready),
      .key_event  (key_event),
      .mods       (mods)
   );

   // ****************************************
   // one decoder per keymap row
   // ****************************************
   for (genvar r = 1; r <= `KB_ROWS; r++) begin : g_row
      key_row_decoder #(
         .ROW (r)
      ) key_row_decoder_inst (
         .code    (key_event.code),
         .row_hit (row_hits[r])
      );
   end

   held_key_latch held_key_latch_inst (
      .I_CLK       (I_CLK),
      .I_RST       (I_RST),
      .key_event   (key_event),
      .row_hits    (row_hits),
      .cpu_iorq    (cpu_iorq),
      .cpu_port00h (cpu_port00h),
      .held        (held)
   );

   port_read_mux port_read_mux_inst (
      .I_CLK    (I_CLK),
      .I_RST    (I_RST),
      .cpu_addr (cpu_addr),
      .mods     (mods),
      .held     (held),
      .key_data (key_data)
   );

endmodule

//--- test/keyboard_model.svh
// keyboard model with its own keymap copy; every accepted byte is applied once, in order
`ifndef KEYBOARD_MODEL_SVH
`define KEYBOARD_MODEL_SVH

// ****************************************
// keymap copy, row r bit b at index (r-1)*8+b
// ****************************************
localparam logic [7:0] ref_codes [0:71] = '{
   8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h5A,   // enter only
   8'h54, 8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34,
   8'h33, 8'h43, 8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44,
   8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D,
   8'h22, 8'h35, 8'h1A, 8'h5B, 8'h6A, 8'h5D, 8'h55, 8'h4E,
   8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D,
   8'h3E, 8'h46, 8'h52, 8'h4C, 8'h41, 8'h49, 8'h4A, 8'h51,
   8'h6C, 8'h75, 8'h74, 8'h71, 8'h00, 8'h00, 8'h00, 8'h00,   // home up right del
   8'h77, 8'h05, 8'h06, 8'h04, 8'h0C, 8'h03, 8'h29, 8'h76
};

// down, left, ins on row 8 bits 1..3, with shift
localparam logic [7:0] ref_shifted [1:3] = '{8'h72, 8'h6B, 8'h70};

logic       mdl_shift;
logic       mdl_kana;
logic       mdl_ctrl;
logic       mdl_graph;
logic       mdl_brk;
logic       mdl_valid;     // held key
logic [3:0] mdl_row;
logic       mdl_sh;
logic [7:0] mdl_bits;
int         mdl_reads;

task automatic clear_model();
   mdl_shift = 1'b0;
   mdl_kana  = 1'b0;
   mdl_ctrl  = 1'b0;
   mdl_graph = 1'b0;
   mdl_brk   = 1'b0;
   mdl_valid = 1'b0;
   mdl_row   = 4'h0;
   mdl_sh    = 1'b0;
   mdl_bits  = 8'h00;
   mdl_reads = 0;
endtask

task automatic apply_key(input logic [7:0] code);
   mdl_valid = 1'b0;   // a miss drops the key
   mdl_row   = 4'h0;
   mdl_sh    = 1'b0;
   mdl_bits  = 8'h00;
   for (int i = 71; i >= 0; i--) begin
      if ((ref_codes[i] != 8'h00) && (ref_codes[i] == code)) begin
         mdl_valid = 1'b1;
         mdl_row   = 4'(i / 8 + 1);
         mdl_bits  = 8'h01 << (i % 8);
      end
   end
   for (int b = 1; b <= 3; b++) begin
      if (ref_shifted[b] == code) begin
         mdl_valid = 1'b1;
         mdl_row   = 4'h8;
         mdl_sh    = 1'b1;
         mdl_bits  = 8'h01 << b;
      end
   end
endtask

task automatic apply_byte(input logic [7:0] b);
   if (b == `KB_BREAK_CODE) begin
      mdl_brk = 1'b1;
   end else if (mdl_brk) begin
      mdl_brk = 1'b0;   // release, no event
      case (b)
         `KB_CODE_SHIFT: mdl_shift = 1'b0;
         `KB_CODE_KANA:  mdl_kana  = 1'b0;
         `KB_CODE_CTRL:  mdl_ctrl  = 1'b0;
         `KB_CODE_GRAPH: mdl_graph = 1'b0;
         default:        ;
      endcase
   end else begin
      case (b)
         `KB_CODE_SHIFT: mdl_shift = 1'b1;
         `KB_CODE_KANA:  mdl_kana  = 1'b1;
         `KB_CODE_CTRL:  mdl_ctrl  = 1'b1;
         `KB_CODE_GRAPH: mdl_graph = 1'b1;
         default:        apply_key(b);
      endcase
   end
endtask

task automatic count_scan_read(input logic port00h);
   if (port00h && mdl_valid) begin
      if (mdl_reads == `KB_RELEASE_READS - 1) begin
         mdl_valid = 1'b0;
         mdl_reads = 0;
      end else begin
         mdl_reads = mdl_reads + 1;
      end
   end
endtask

function automatic logic [7:0] expected_data(input logic [3:0] addr);
   logic       mod_row;
   logic [7:0] d;
   mod_row = (addr == 4'h8);
   if (mod_row && mdl_shift) d = 8'h40;
   else if (mod_row && mdl_valid && mdl_sh) d = 8'h40 | mdl_bits;
   else if (mod_row && mdl_kana) d = 8'h20;
   else if (mod_row && mdl_graph) d = 8'h10;
   else if (mod_row && mdl_ctrl) d = 8'h80;
   else if (mdl_valid && (addr == mdl_row)) d = mdl_bits;
   else d = 8'h00;
   return d;
endfunction

`endif

//--- test/tb_pc8001_keyboard.sv
// testbench for pc8001_keyboard; fixed-seed random bytes and CPU reads, checked against a model
`timescale 1ns/1ps
`include "kb_defs.svh"

module tb_pc8001_keyboard;

   localparam int n_make   = 40;
   localparam int n_mod    = 60;
   // bytes and reads take eight cycles each at most
   localparam int max_ops  = 16 + n_make * 17 + n_mod * 4 + 8 + 12 + 80;
   localparam int limit_ns = (max_ops * 8 + 200) * 40;

   localparam logic [7:0] row8_codes [0:5] = '{8'h75, 8'h72, 8'h74, 8'h6B, 8'h71, 8'h70};
   localparam logic [7:0] row8_data  [0:5] = '{8'h02, 8'h42, 8'h04, 8'h44, 8'h08, 8'h48};

   logic       I_CLK;
   logic       I_RST;
   logic [7:0] scan_code;
   logic       scan_valid;
   logic       scan_ready;
   logic [3:0] cpu_addr;
   logic       cpu_iorq;
   logic       cpu_port00h;
   logic [7:0] key_data;
   integer     seed;

   `include "keyboard_model.svh"

   pc8001_keyboard pc8001_keyboard_inst (
      .I_CLK       (I_CLK),
      .I_RST       (I_RST),
      .scan_code   (scan_code),
      .scan_valid  (scan_valid),
      .scan_ready  (scan_ready),
      .cpu_addr    (cpu_addr),
      .cpu_iorq    (cpu_iorq),
      .cpu_port00h (cpu_port00h),
      .key_data    (key_data)
   );

   always #20 I_CLK = ~I_CLK;   // 40 ns period

   // ****************************************
   // helpers start and end on a falling edge
   // ****************************************
   task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] want);
      if (got !== want) begin
         $display("Error: %s is %h, expected %h", name, got, want);
         $display("SOME TESTS FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(negedge I_CLK);
         check_value("scan_ready", {7'd0, scan_ready}, 8'h01);
      end
   endtask

   task automatic send_byte(input logic [7:0] b);
      idle_cycles({$random(seed)} % 4);   // random valid gap
      scan_code  = b;
      scan_valid = 1'b1;
      check_value("scan_ready", {7'd0, scan_ready}, 8'h01);
      @(negedge I_CLK);
      check_value("scan_ready", {7'd0, scan_ready}, 8'h00);   // gap after acceptance
      scan_valid = 1'b0;
      scan_code  = 8'($random(seed));
      apply_byte(b);
      idle_cycles(4);
   endtask

   task automatic read_and_check(input logic [3:0] addr);
      logic [7:0] want;
      cpu_addr = addr;
      want     = expected_data(addr);
      @(negedge I_CLK);
      check_value($sformatf("key_data[%0d]", addr), key_data, want);
   endtask

   task automatic read_all(output logic [7:0] any_bits);
      any_bits = 8'h00;
      for (int a = 0; a < 16; a++) begin
         read_and_check(4'(a));
         any_bits = any_bits | key_data;
      end
   endtask

   task automatic iorq_pulse(input logic port);
      cpu_port00h = port;
      cpu_iorq    = 1'b0;
      repeat (3) @(negedge I_CLK);
      cpu_iorq = 1'b1;   // rising edge seen after the synchronizer
      repeat (3) @(negedge I_CLK);
      cpu_port00h = 1'b0;
      count_scan_read(port);
   endtask

   task automatic random_table_code(output logic [7:0] code);
      int idx;
      code = 8'h00;
      while (code == 8'h00) begin
         idx = {$random(seed)} % 75;
         if (idx < 72) code = ref_codes[idx];
         else code = ref_shifted[idx - 71];
      end
   endtask

   function automatic logic is_modifier(input logic [7:0] c);
      return (c == `KB_CODE_SHIFT) || (c == `KB_CODE_KANA) ||
             (c == `KB_CODE_CTRL) || (c == `KB_CODE_GRAPH);
   endfunction

   // code present anywhere in the keymap, plain or shifted
   function automatic logic in_keymap(input logic [7:0] c);
      logic found;
      found = 1'b0;
      for (int i = 0; i < 72; i++) begin
         if ((ref_codes[i] != 8'h00) && (ref_codes[i] == c)) begin
            found = 1'b1;
         end
      end
      for (int b = 1; b <= 3; b++) begin
         if (ref_shifted[b] == c) begin
            found = 1'b1;
         end
      end
      return found;
   endfunction

   task automatic random_other_code(output logic [7:0] code);
      code = `KB_BREAK_CODE;
      while ((code == `KB_BREAK_CODE) || is_modifier(code)) begin
         code = 8'($random(seed));
      end
   endtask

   task automatic random_modifier(output logic [7:0] code);
      case ({$random(seed)} % 4)
         0:       code = `KB_CODE_SHIFT;
         1:       code = `KB_CODE_KANA;
         2:       code = `KB_CODE_CTRL;
         default: code = `KB_CODE_GRAPH;
      endcase
   endtask

   // ****************************************
   // watchdog
   // ****************************************
   initial begin
      #(limit_ns);
      $display("watchdog expired, the run stopped making progress");
      $display("SOME TESTS FAILED");
      $fatal(1, "timeout");
   end

   // ****************************************
   // test sequence
   // ****************************************
   initial begin
      logic [7:0] c;
      logic [7:0] any_bits;
      seed        = 32'hd8e0;
      I_CLK       = 1'b0;
      I_RST       = 1'b1;
      scan_code   = 8'h00;
      scan_valid  = 1'b0;
      cpu_addr    = 4'h0;
      cpu_iorq    = 1'b1;   // idle high
      cpu_port00h = 1'b0;
      clear_model();
      repeat (2) @(posedge I_CLK);
      @(negedge I_CLK);
      I_RST = 1'b0;

      // reset state
      check_value("scan_ready", {7'd0, scan_ready}, 8'h01);
      read_all(any_bits);
      check_value("key_data", any_bits, 8'h00);

      // known and unknown make codes
      repeat (n_make) begin
         if ($random(seed) & 1) random_table_code(c);
         else random_other_code(c);
         send_byte(c);
         read_all(any_bits);
         if (!in_keymap(c)) check_value("key_data", any_bits, 8'h00);
      end

      // modifier presses, releases, stray breaks
      repeat (n_mod) begin
         case ({$random(seed)} % 4)
            0: begin
               random_modifier(c);
               send_byte(c);
            end
            1: begin
               random_modifier(c);
               send_byte(`KB_BREAK_CODE);
               send_byte(c);
            end
            2: begin
               random_other_code(c);   // break of a key that is not held
               send_byte(`KB_BREAK_CODE);
               send_byte(c);
            end
            default: begin
               random_table_code(c);
               send_byte(c);
            end
         endcase
         read_and_check(4'h8);
         read_and_check(4'($random(seed)));
      end
      send_byte(`KB_BREAK_CODE);
      send_byte(`KB_CODE_SHIFT);
      send_byte(`KB_BREAK_CODE);
      send_byte(`KB_CODE_KANA);
      send_byte(`KB_BREAK_CODE);
      send_byte(`KB_CODE_CTRL);
      send_byte(`KB_BREAK_CODE);
      send_byte(`KB_CODE_GRAPH);

      // shifted and plain row 8 keys
      for (int k = 0; k < 6; k++) begin
         send_byte(row8_codes[k]);
         cpu_addr = 4'h8;
         @(negedge I_CLK);
         check_value("key_data[8]", key_data, row8_data[k]);
      end

      // scan release with the counter running on across a new key
      random_table_code(c);
      send_byte(c);
      repeat (6) begin
         iorq_pulse(1'b1);
         read_and_check(mdl_row);
      end
      repeat (5) begin
         iorq_pulse(1'b0);   // other port is not counted
         read_and_check(mdl_row);
      end
      random_table_code(c);
      send_byte(c);
      repeat (7) begin
         iorq_pulse(1'b1);
         read_and_check(mdl_row);
      end
      read_all(any_bits);
      check_value("key_data held", {7'd0, any_bits != 8'h00}, 8'h01);
      iorq_pulse(1'b1);
      read_all(any_bits);
      check_value("key_data", any_bits, 8'h00);

      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

//--- sim.f
+incdir+common
+incdir+test
common/kb_pkg.sv
keymap/key_row_decoder.sv
keymap/held_key_latch.sv
source/scan_code_intake.sv
source/port_read_mux.sv
source/pc8001_keyboard.sv
test/tb_pc8001_keyboard.sv

//--- run_sim.sh
#!/bin/sh
# build and run the keyboard testbench; a failing check ends in $fatal and a nonzero status
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
   --top-module tb_pc8001_keyboard \
   -f sim.f \
   -o tb_pc8001_keyboard

./obj_dir/tb_pc8001_keyboard
